/* Makefile */
SIM := obj_dir/Vtb_srtc

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): filelist.f $(wildcard logic/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_srtc -f filelist.f -o Vtb_srtc

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* filelist.f */
logic/srtc_pkg.sv
logic/srtc_strobe_sync.sv
logic/srtc.sv
logic/rtc_timekeeper.sv
logic/srtc_top.sv
verif/srtc_checker.sv
verif/tb_srtc.sv

/* logic/rtc_timekeeper.sv */
`timescale 1ns/10ps

module rtc_timekeeper import srtc_pkg::*; #(
  parameter int TICK_DIVIDER = TICKS_PER_SECOND
) (
  input  logic                      clkin,
  input  logic                      reset_rising,
  input  logic                      load,
  input  logic [SRTC_WORD_BITS-1:0] load_word,
  output logic [SRTC_WORD_BITS-1:0] rtc_time
);

  localparam int PRESC_BITS = $clog2(TICK_DIVIDER);

  // Jan 1 00:00:00, year 2000, weekday 0
  localparam logic [SRTC_WORD_BITS-1:0] RESET_WORD =
    (60'h1 << (DAY_LO * 4)) | (60'h1 << (MON_LO * 4)) | (60'h2 << (CENT_HI * 4));

  logic [PRESC_BITS-1:0] presc_r;
  logic                  tick;

  // Two-digit BCD increment, wraps to base past limit
  function automatic logic [7:0] bcd_step(
    input logic [7:0] v,
    input logic [7:0] limit,
    input logic [7:0] base
  );
    logic [7:0] inc;
    if (v >= limit) begin
      return base;
    end
    inc = (v[3:0] >= 4'd9) ? {v[7:4] + 4'd1, 4'd0} : {v[7:4], v[3:0] + 4'd1};
    return inc;
  endfunction

  function automatic logic [SRTC_WORD_BITS-1:0] advance_second(
    input logic [SRTC_WORD_BITS-1:0] cur
  );
    logic [SRTC_WORD_BITS-1:0] nxt;
    logic [7:0]                sec_v;
    logic [7:0]                min_v;
    logic [7:0]                hour_v;
    logic [7:0]                day_v;
    logic [7:0]                year_v;
    logic [7:0]                month_v;
    logic [7:0]                last_day;
    logic [3:0]                wday_v;
    logic                      min_step;
    logic                      hour_step;
    logic                      day_step;
    logic                      mon_step;
    logic                      year_step;
    sec_v   = cur[SEC_LO*4 +: 8];
    min_v   = cur[MIN_LO*4 +: 8];
    hour_v  = cur[HOUR_LO*4 +: 8];
    day_v   = cur[DAY_LO*4 +: 8];
    year_v  = cur[YEAR_LO*4 +: 8];
    wday_v  = cur[WDAY*4 +: 4];
    // Month is kept as tens flag plus ones
    month_v = {4'd0, cur[MON_LO*4 +: 4]} + {4'd0, cur[MON_HI*4 +: 4]} * 8'd10;
    case (month_v)
      8'd2:                    last_day = 8'h28;
      8'd4, 8'd6, 8'd9, 8'd11: last_day = 8'h30;
      default:                 last_day = 8'h31;
    endcase
    // Carry chain
    min_step  = (sec_v >= 8'h59);
    hour_step = min_step && (min_v >= 8'h59);
    day_step  = hour_step && (hour_v >= 8'h23);
    mon_step  = day_step && (day_v >= last_day);
    year_step = mon_step && (month_v >= 8'd12);
    nxt = cur;
    nxt[SEC_LO*4 +: 8] = bcd_step(sec_v, 8'h59, 8'h00);
    if (min_step) begin
      nxt[MIN_LO*4 +: 8] = bcd_step(min_v, 8'h59, 8'h00);
    end
    if (hour_step) begin
      nxt[HOUR_LO*4 +: 8] = bcd_step(hour_v, 8'h23, 8'h00);
    end
    if (day_step) begin
      nxt[DAY_LO*4 +: 8] = bcd_step(day_v, last_day, 8'h01);
      nxt[WDAY*4 +: 4]   = (wday_v >= 4'd6) ? 4'd0 : wday_v + 4'd1;
    end
    if (mon_step) begin
      month_v = (month_v >= 8'd12) ? 8'd1 : month_v + 8'd1;
      nxt[MON_LO*4 +: 4] = (month_v >= 8'd10) ? month_v[3:0] - 4'd10 : month_v[3:0];
      nxt[MON_HI*4 +: 4] = (month_v >= 8'd10) ? 4'd1 : 4'd0;
    end
    // Century stays put
    if (year_step) begin
      nxt[YEAR_LO*4 +: 8] = bcd_step(year_v, 8'h99, 8'h00);
    end
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Prescaler and time register
  ////////////////////////////////////////////////////////////////////////////

  assign tick = (presc_r == PRESC_BITS'(TICK_DIVIDER - 1));

  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      rtc_time <= RESET_WORD;
      presc_r  <= '0;
    end else if (load) begin
      // New word restarts the second
      rtc_time <= load_word;
      presc_r  <= '0;
    end else if (tick) begin
      rtc_time <= advance_second(rtc_time);
      presc_r  <= '0;
    end else begin
      presc_r <= presc_r + PRESC_BITS'(1);
    end
  end

  a_sec_tens: assert property (@(posedge clkin) disable iff (reset_rising)
    rtc_time[SEC_HI*4 +: 4] <= 4'd5)
    else $error("seconds tens digit above 5");

endmodule

/* logic/srtc.sv */
`timescale 1ns/10ps

module srtc import srtc_pkg::*; (
  input  logic                      clkin,
  input  logic                      reset_rising,
  input  logic                      we_rise,
  input  logic                      oe_fall,
  input  logic                      enable,
  input  logic                      addr_in,
  input  logic [3:0]                data_in,
  input  logic [SRTC_WORD_BITS-1:0] rtc_data_in,
  output logic [7:0]                data_out,
  output logic [SRTC_WORD_BITS-1:0] rtc_data_out,
  output logic                      rtc_we
);

  srtc_mode_t                mode_r;
  logic [3:0]                rtc_ptr;
  logic [2:0]                we_countdown;
  // Time snapshot taken at the parked pointer
  logic [SRTC_WORD_BITS-1:0] read_word;

  // Ones digit of a 0..15 console value
  function automatic logic [3:0] split_ones(input logic [3:0] d);
    return (d < 4'd10) ? d : d - 4'd10;
  endfunction

  function automatic logic [7:0] join_tens(input logic [3:0] lo, input logic [3:0] hi);
    return {4'd0, lo} + {4'd0, hi} * 8'd10;
  endfunction

  // Console view of one pointer position
  function automatic logic [7:0] read_nibble(
    input logic [SRTC_WORD_BITS-1:0] w,
    input logic [3:0]                ptr
  );
    logic [7:0] r;
    case (ptr)
      4'd8:  r = join_tens(w[MON_LO*4 +: 4], w[MON_HI*4 +: 4]);
      4'd9:  r = {4'd0, w[YEAR_LO*4 +: 4]};
      4'd10: r = {4'd0, w[YEAR_HI*4 +: 4]};
      // Century tens of 1 or 2 maps to 9 or 10
      4'd11: r = join_tens(w[CENT_LO*4 +: 4], w[CENT_HI*4 +: 4]) - 8'd10;
      4'd12: r = {4'd0, w[WDAY*4 +: 4]};
      default: begin
        if (ptr < 4'd8) begin
          r = {4'd0, w[{ptr, 2'b00} +: 4]};
        end else begin
          r = 8'h0f;
        end
      end
    endcase
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Mode machine, write packing and read path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      mode_r       <= READ;
      rtc_ptr      <= PTR_PARK;
      rtc_we       <= 1'b0;
      we_countdown <= '0;
      data_out     <= 8'h00;
    end else if (mode_r == WRITE2) begin
      // Hold the load strobe, strobes ignored meanwhile
      we_countdown <= we_countdown - 3'd1;
      if (we_countdown == 3'd0) begin
        mode_r <= WRITE;
        rtc_we <= 1'b0;
      end
    end else if (we_rise && enable) begin
      // Address 0 is read only
      if (addr_in) begin
        case (data_in)
          CMD_READ_RESET: begin
            mode_r  <= READ;
            rtc_ptr <= PTR_PARK;
          end
          CMD_COMMAND: begin
            mode_r <= COMMAND;
          end
          CMD_NOP: begin
          end
          default: begin
            if (mode_r == COMMAND) begin
              if (data_in == CMD_WRITE) begin
                mode_r       <= WRITE;
                rtc_data_out <= rtc_data_in;
                rtc_ptr      <= 4'd0;
              end else if (data_in == CMD_CLEAR) begin
                mode_r  <= IDLE;
                rtc_ptr <= PTR_PARK;
              end else begin
                mode_r <= IDLE;
              end
            end else if (mode_r == WRITE) begin
              case (rtc_ptr)
                4'd8: begin
                  rtc_data_out[MON_LO*4 +: 4] <= split_ones(data_in);
                  rtc_data_out[MON_HI*4 +: 4] <= (data_in < 4'd10) ? 4'd0 : 4'd1;
                end
                4'd9:  rtc_data_out[YEAR_LO*4 +: 4] <= data_in;
                4'd10: rtc_data_out[YEAR_HI*4 +: 4] <= data_in;
                4'd11: begin
                  rtc_data_out[CENT_LO*4 +: 4] <= split_ones(data_in);
                  rtc_data_out[CENT_HI*4 +: 4] <= (data_in < 4'd10) ? 4'd1 : 4'd2;
                end
                4'd12: rtc_data_out[WDAY*4 +: 4] <= data_in;
                default: begin
                  // Seconds through days go straight in
                  if (rtc_ptr < 4'd8) begin
                    rtc_data_out[{rtc_ptr, 2'b00} +: 4] <= data_in;
                  end
                end
              endcase
              rtc_ptr      <= rtc_ptr + 4'd1;
              mode_r       <= WRITE2;
              we_countdown <= WE_HOLD_CYCLES;
              rtc_we       <= 1'b1;
            end
          end
        endcase
      end
    end else if (oe_fall && enable && !addr_in) begin
      if (mode_r == READ) begin
        if (rtc_ptr == PTR_PARK) begin
          read_word <= rtc_data_in;
          data_out  <= 8'h0f;
        end else begin
          data_out <= read_nibble(read_word, rtc_ptr);
        end
        // Last nibble is 12, then 13 reads 0f and parks
        rtc_ptr <= (rtc_ptr == 4'd13) ? PTR_PARK : rtc_ptr + 4'd1;
      end else begin
        data_out <= 8'h00;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_mode_onehot: assert property (@(posedge clkin) disable iff (reset_rising)
    $onehot(mode_r))
    else $error("decoder mode is not one-hot");

  // Load strobe only while the write is being committed
  a_we_in_write2: assert property (@(posedge clkin) disable iff (reset_rising)
    rtc_we |-> (mode_r == WRITE2))
    else $error("rtc_we high outside WRITE2");

endmodule

/* logic/srtc_pkg.sv */
package srtc_pkg;

  // Packed time word, fifteen nibbles
  localparam int SRTC_WORD_BITS = 60;

  // Nibble index of each field inside the time word
  localparam int SEC_LO  = 0;
  localparam int SEC_HI  = 1;
  localparam int MIN_LO  = 2;
  localparam int MIN_HI  = 3;
  localparam int HOUR_LO = 4;
  localparam int HOUR_HI = 5;
  localparam int DAY_LO  = 6;
  localparam int DAY_HI  = 7;
  localparam int MON_LO  = 8;
  localparam int MON_HI  = 9;
  localparam int YEAR_LO = 10;
  localparam int YEAR_HI = 11;
  localparam int CENT_LO = 12;
  localparam int CENT_HI = 13;
  localparam int WDAY    = 14;

  // Control register commands
  localparam logic [3:0] CMD_READ_RESET = 4'hd;
  localparam logic [3:0] CMD_COMMAND    = 4'he;
  localparam logic [3:0] CMD_NOP        = 4'hf;
  localparam logic [3:0] CMD_WRITE      = 4'h0;
  localparam logic [3:0] CMD_CLEAR      = 4'h4;

  // Decoder modes, one-hot
  typedef enum logic [4:0] {
    IDLE    = 5'b00001,
    READ    = 5'b00010,
    COMMAND = 5'b00100,
    WRITE   = 5'b01000,
    WRITE2  = 5'b10000
  } srtc_mode_t;

  // Parked pointer, next read grabs a fresh snapshot
  localparam logic [3:0] PTR_PARK = 4'd15;

  localparam logic [2:0] WE_HOLD_CYCLES = 3'd5;

  // Clock cycles per second, simulation scale
  localparam int TICKS_PER_SECOND = 64;

endpackage

/* logic/srtc_strobe_sync.sv */
`timescale 1ns/10ps

module srtc_strobe_sync (
  input  logic clkin,
  input  logic reset_rising,
  input  logic reg_we,
  input  logic reg_oe,
  output logic we_rise,
  output logic oe_fall
);

  // Strobe history, newest sample in bit 0
  logic [5:0] we_hist;
  logic [5:0] oe_hist;

  always_ff @(posedge clkin) begin
    if (reset_rising) begin
      we_hist <= '0;
      oe_hist <= '0;
    end else begin
      we_hist <= {we_hist[4:0], reg_we};
      oe_hist <= {oe_hist[4:0], reg_oe};
    end
  end

  // Four stable samples then the new level
  assign we_rise = (we_hist[5:1] == 5'b00001);
  assign oe_fall = (oe_hist[5:1] == 5'b11110);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Edge pulses last exactly one cycle
  a_we_single: assert property (@(posedge clkin) disable iff (reset_rising)
    we_rise |=> !we_rise)
    else $error("we_rise held for more than one cycle");

  a_oe_single: assert property (@(posedge clkin) disable iff (reset_rising)
    oe_fall |=> !oe_fall)
    else $error("oe_fall held for more than one cycle");

endmodule

/* logic/srtc_top.sv */
`timescale 1ns/10ps

module srtc_top import srtc_pkg::*; (
  input  logic       clkin,
  input  logic       reset_rising,
  input  logic       addr_in,
  input  logic [3:0] data_in,
  input  logic       reg_we,
  input  logic       reg_oe,
  input  logic       enable,
  output logic [7:0] data_out
);

  logic                      we_rise;
  logic                      oe_fall;
  logic                      rtc_we;
  // Decoder to timekeeper and back
  logic [SRTC_WORD_BITS-1:0] rtc_load_word;
  logic [SRTC_WORD_BITS-1:0] rtc_time;

  srtc_strobe_sync u_strobe_sync (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .reg_we       (reg_we),
    .reg_oe       (reg_oe),
    .we_rise      (we_rise),
    .oe_fall      (oe_fall)
  );

  srtc u_srtc (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .we_rise      (we_rise),
    .oe_fall      (oe_fall),
    .enable       (enable),
    .addr_in      (addr_in),
    .data_in      (data_in),
    .rtc_data_in  (rtc_time),
    .data_out     (data_out),
    .rtc_data_out (rtc_load_word),
    .rtc_we       (rtc_we)
  );

  rtc_timekeeper #(
    .TICK_DIVIDER (TICKS_PER_SECOND)
  ) u_timekeeper (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .load         (rtc_we),
    .load_word    (rtc_load_word),
    .rtc_time     (rtc_time)
  );

endmodule

/* verif/srtc_checker.sv */
`timescale 1ns/10ps

module srtc_checker import srtc_pkg::*; (
  input  logic                      clkin,
  input  logic                      reset_rising,
  input  logic [7:0]                data_out,
  input  logic                      sample,
  input  logic [3:0]                sample_ptr,
  input  logic                      sample_idle,
  input  logic                      set_ref,
  input  logic [SRTC_WORD_BITS-1:0] ref_word,
  output int                        err_count,
  output int                        check_count
);

  logic [SRTC_WORD_BITS-1:0] ref_r;
  int                        cycles;
  // Snapshot candidates, one second either side
  logic [SRTC_WORD_BITS-1:0] cand [0:2];
  logic [2:0]                cand_ok;

  // Two nibbles as ones plus tens, binary value
  function automatic int field_val(input logic [SRTC_WORD_BITS-1:0] w, input int lo_idx);
    return int'(w[lo_idx*4 +: 4]) + 10 * int'(w[(lo_idx+1)*4 +: 4]);
  endfunction

  function automatic logic [SRTC_WORD_BITS-1:0] put_field(
    input logic [SRTC_WORD_BITS-1:0] w,
    input int                        lo_idx,
    input int                        val
  );
    logic [SRTC_WORD_BITS-1:0] r;
    r = w;
    r[lo_idx*4 +: 4]     = 4'(val % 10);
    r[(lo_idx+1)*4 +: 4] = 4'(val / 10);
    return r;
  endfunction

  function automatic int days_in_month(input int mon);
    case (mon)
      2:           return 28;
      4, 6, 9, 11: return 30;
      default:     return 31;
    endcase
  endfunction

  // Jan 1 00:00:00, year 00 of century 20, weekday 0
  function automatic logic [SRTC_WORD_BITS-1:0] reset_word();
    logic [SRTC_WORD_BITS-1:0] w;
    w = '0;
    w = put_field(w, DAY_LO, 1);
    w = put_field(w, MON_LO, 1);
    w = put_field(w, CENT_LO, 20);
    return w;
  endfunction

  function automatic logic [SRTC_WORD_BITS-1:0] advance_second(
    input logic [SRTC_WORD_BITS-1:0] w
  );
    int                        sec;
    int                        min;
    int                        hour;
    int                        day;
    int                        mon;
    int                        year;
    int                        wday;
    logic [SRTC_WORD_BITS-1:0] n;
    sec  = field_val(w, SEC_LO) + 1;
    min  = field_val(w, MIN_LO);
    hour = field_val(w, HOUR_LO);
    day  = field_val(w, DAY_LO);
    mon  = field_val(w, MON_LO);
    year = field_val(w, YEAR_LO);
    wday = int'(w[WDAY*4 +: 4]);
    if (sec == 60) begin
      sec = 0;
      min = min + 1;
    end
    if (min == 60) begin
      min  = 0;
      hour = hour + 1;
    end
    if (hour == 24) begin
      hour = 0;
      day  = day + 1;
      wday = (wday + 1) % 7;
    end
    if (day > days_in_month(mon)) begin
      day = 1;
      mon = mon + 1;
    end
    // No century carry
    if (mon == 13) begin
      mon  = 1;
      year = (year + 1) % 100;
    end
    n = put_field(w, SEC_LO, sec);
    n = put_field(n, MIN_LO, min);
    n = put_field(n, HOUR_LO, hour);
    n = put_field(n, DAY_LO, day);
    n = put_field(n, MON_LO, mon);
    n = put_field(n, YEAR_LO, year);
    n[WDAY*4 +: 4] = 4'(wday);
    return n;
  endfunction

  // Console value at one pointer position
  function automatic logic [7:0] expected_nibble(
    input logic [SRTC_WORD_BITS-1:0] w,
    input logic [3:0]                ptr
  );
    case (ptr)
      4'd8:         return 8'(field_val(w, MON_LO));
      4'd9:         return {4'd0, w[YEAR_LO*4 +: 4]};
      4'd10:        return {4'd0, w[YEAR_HI*4 +: 4]};
      // Century 20 reads back as 10
      4'd11:        return 8'(field_val(w, CENT_LO) - 10);
      4'd12:        return {4'd0, w[WDAY*4 +: 4]};
      4'd13, 4'd15: return 8'h0f;
      default:      return {4'd0, w[int'(ptr)*4 +: 4]};
    endcase
  endfunction

  function automatic string field_name(input logic [3:0] ptr);
    case (ptr)
      4'd0, 4'd1:  return "seconds";
      4'd2, 4'd3:  return "minutes";
      4'd4, 4'd5:  return "hours";
      4'd6, 4'd7:  return "day";
      4'd8:        return "month";
      4'd9, 4'd10: return "year";
      4'd11:       return "century";
      4'd12:       return "weekday";
      default:     return "end marker";
    endcase
  endfunction

  task automatic report_mismatch(input string what, input logic [7:0] expv);
    $display("Mismatch at %0t: %s read %h, expected %h", $time, what, data_out, expv);
    err_count <= err_count + 1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference tracking and read comparison
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clkin) begin
    logic [SRTC_WORD_BITS-1:0] w;
    logic [2:0]                ok;
    int                        secs;
    if (reset_rising) begin
      ref_r       <= reset_word();
      cycles      <= 0;
      cand_ok     <= '0;
      err_count   <= 0;
      check_count <= 0;
    end else begin
      if (set_ref) begin
        ref_r  <= ref_word;
        cycles <= 0;
      end else begin
        cycles <= cycles + 1;
      end
      if (sample) begin
        check_count <= check_count + 1;
        if (sample_idle) begin
          if (data_out !== 8'h00) begin
            report_mismatch("idle read", 8'h00);
          end
        end else if (sample_ptr == PTR_PARK) begin
          // Fresh snapshot in the DUT
          secs = cycles / TICKS_PER_SECOND;
          w = ref_r;
          for (int i = 0; i < secs - 1; i++) begin
            w = advance_second(w);
          end
          cand[0] <= w;
          if (secs > 0) begin
            w = advance_second(w);
          end
          cand[1] <= w;
          cand[2] <= advance_second(w);
          cand_ok <= 3'b111;
          if (data_out !== 8'h0f) begin
            report_mismatch("snapshot marker", 8'h0f);
          end
        end else begin
          ok = cand_ok;
          for (int i = 0; i < 3; i++) begin
            if (data_out !== expected_nibble(cand[i], sample_ptr)) begin
              ok[i] = 1'b0;
            end
          end
          // Keep the old set so one bad nibble does not cascade
          if (ok == 3'b000) begin
            report_mismatch(field_name(sample_ptr),
                            expected_nibble(cand[1], sample_ptr));
          end else begin
            cand_ok <= ok;
          end
        end
      end
    end
  end

endmodule

/* verif/tb_srtc.sv */
`timescale 1ns/10ps

module tb_srtc import srtc_pkg::*; ();

  // Access lengths in clock cycles, these size the watchdog
  localparam int ACCESS_CYCLES   = 24;
  localparam int ACCESS_COUNT    = 160;
  localparam int WAIT_SECONDS    = 5;
  localparam int WATCHDOG_CYCLES =
    2 * (WAIT_SECONDS * TICKS_PER_SECOND + ACCESS_COUNT * ACCESS_CYCLES);

  logic                      clkin;
  logic                      reset_rising;
  logic                      addr_in;
  logic [3:0]                data_in;
  logic                      reg_we;
  logic                      reg_oe;
  logic                      enable;
  logic [7:0]                data_out;
  logic                      sample;
  logic [3:0]                sample_ptr;
  logic                      sample_idle;
  logic                      set_ref;
  logic [SRTC_WORD_BITS-1:0] ref_word;
  int                        err_count;
  int                        check_count;
  integer                    seed;

  srtc_top i_dut (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .addr_in      (addr_in),
    .data_in      (data_in),
    .reg_we       (reg_we),
    .reg_oe       (reg_oe),
    .enable       (enable),
    .data_out     (data_out)
  );

  srtc_checker u_checker (
    .clkin        (clkin),
    .reset_rising (reset_rising),
    .data_out     (data_out),
    .sample       (sample),
    .sample_ptr   (sample_ptr),
    .sample_idle  (sample_idle),
    .set_ref      (set_ref),
    .ref_word     (ref_word),
    .err_count    (err_count),
    .check_count  (check_count)
  );

  initial begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  // Lands 2 ns past the n-th rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clkin);
    #2;
  endtask

  task automatic console_write(input logic a, input logic [3:0] d);
    addr_in = a;
    data_in = d;
    reg_we  = 1'b1;
    wait_cycles(8);
    reg_we  = 1'b0;
    wait_cycles(8);
  endtask

  task automatic toggle_oe();
    addr_in = 1'b0;
    reg_oe  = 1'b1;
    wait_cycles(8);
    reg_oe  = 1'b0;
    wait_cycles(6);
  endtask

  task automatic console_read(input logic [3:0] ptr, input logic idle);
    toggle_oe();
    sample_ptr  = ptr;
    sample_idle = idle;
    sample      = 1'b1;
    wait_cycles(1);
    sample      = 1'b0;
  endtask

  // Pointer walks 15, 0..12, then 13 and parks again
  task automatic read_all_nibbles();
    console_read(PTR_PARK, 1'b0);
    for (int p = 0; p <= 13; p++) begin
      console_read(4'(p), 1'b0);
    end
  endtask

  task automatic read_sequence();
    console_write(1'b1, CMD_READ_RESET);
    read_all_nibbles();
  endtask

  function automatic logic [7:0] bcd_pair(input int v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  function automatic int random_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic set_time(
    input int sec, input int min, input int hour, input int day,
    input int mon, input int year, input int wday
  );
    logic [3:0] nibs [0:12];
    nibs[0]  = 4'(sec % 10);
    nibs[1]  = 4'(sec / 10);
    nibs[2]  = 4'(min % 10);
    nibs[3]  = 4'(min / 10);
    nibs[4]  = 4'(hour % 10);
    nibs[5]  = 4'(hour / 10);
    nibs[6]  = 4'(day % 10);
    nibs[7]  = 4'(day / 10);
    nibs[8]  = 4'(mon);
    nibs[9]  = 4'(year % 10);
    nibs[10] = 4'(year / 10);
    // Century 20 is written as 10
    nibs[11] = 4'd10;
    nibs[12] = 4'(wday);
    console_write(1'b1, CMD_COMMAND);
    console_write(1'b1, CMD_WRITE);
    for (int i = 0; i < 13; i++) begin
      console_write(1'b1, nibs[i]);
    end
    ref_word                   = '0;
    ref_word[SEC_LO*4 +: 8]    = bcd_pair(sec);
    ref_word[MIN_LO*4 +: 8]    = bcd_pair(min);
    ref_word[HOUR_LO*4 +: 8]   = bcd_pair(hour);
    ref_word[DAY_LO*4 +: 8]    = bcd_pair(day);
    ref_word[MON_LO*4 +: 8]    = bcd_pair(mon);
    ref_word[YEAR_LO*4 +: 8]   = bcd_pair(year);
    ref_word[CENT_LO*4 +: 8]   = 8'h20;
    ref_word[WDAY*4 +: 4]      = 4'(wday);
    set_ref = 1'b1;
    wait_cycles(1);
    set_ref = 1'b0;
    console_write(1'b1, CMD_READ_RESET);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clkin);
    $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'ha9c3823c;
    reset_rising = 1'b1;
    addr_in      = 1'b0;
    data_in      = 4'd0;
    reg_we       = 1'b0;
    reg_oe       = 1'b0;
    enable       = 1'b1;
    sample       = 1'b0;
    sample_ptr   = 4'd0;
    sample_idle  = 1'b0;
    set_ref      = 1'b0;
    ref_word     = '0;
    repeat (8) @(posedge clkin);
    #2;
    reset_rising = 1'b0;

    // Reset time, straight out of reset with the pointer parked
    read_all_nibbles();

    // Random legal time, day kept below 29
    set_time(random_below(60), random_below(60), random_below(24), random_below(28) + 1,
             random_below(12) + 1, random_below(100), random_below(7));
    read_sequence();

    // New year rollover
    set_time(58, 59, 23, 31, 12, 99, 3);
    wait_cycles(3 * TICKS_PER_SECOND);
    read_sequence();

    // Month ten rolls into November
    set_time(59, 59, 23, 31, 10, 45, 6);
    wait_cycles(2 * TICKS_PER_SECOND);
    read_sequence();

    // IDLE mode reads 0
    console_write(1'b1, CMD_COMMAND);
    console_write(1'b1, CMD_CLEAR);
    console_read(4'd0, 1'b1);
    read_sequence();

    // Disabled bus, time must stay on the reference
    enable = 1'b0;
    console_write(1'b1, CMD_COMMAND);
    console_write(1'b1, CMD_WRITE);
    for (int i = 0; i < 6; i++) begin
      console_write(1'b1, 4'd7);
    end
    console_write(1'b1, CMD_CLEAR);
    toggle_oe();
    toggle_oe();
    enable = 1'b1;
    read_sequence();

    wait_cycles(4);
    $display("Read checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
